// File: erx_cfg.svh
`ifndef ERX_CFG_SVH
`define ERX_CFG_SVH

// Mesh packet field widths
`define ERX_AW 32
`define ERX_DW 32

// Parallel link beat width
`define ERX_LINK_W 64

// Chip ID, compared against dstaddr[31:20]
`define ERX_ID 12'h800

// Queue sizing
`define ERX_FIFO_DEPTH 16
`define ERX_FIFO_MARGIN 6 // Pushback at DEPTH-6 entries

// APB register map
`define ERX_APB_AW 8
`define ERX_REG_CFG 8'h00 // bit0 rx_enable, bit1 remap mode
`define ERX_REG_SEL 8'h04 // Remap select mask
`define ERX_REG_PAT 8'h08 // Remap pattern

`endif

// File: erx_pkg.sv
`include "erx_cfg.svh"

package erx_pkg;

   // Transaction packet, write flag in the LSB
   typedef struct packed {
      logic [`ERX_AW-1:0] srcaddr;
      logic [`ERX_DW-1:0] data;
      logic [`ERX_AW-1:0] dstaddr;
      logic [3:0]         ctrlmode;
      logic [1:0]         datamode;
      logic               write;
   } emesh_packet_t;

   // Destination queue of a packet
   typedef enum logic [1:0] {
      PKT_WRITE,
      PKT_READ,
      PKT_RESP
   } pkt_kind_t;

   typedef enum logic {
      REMAP_NONE,
      REMAP_STATIC
   } remap_mode_t;

   typedef struct packed {
      remap_mode_t mode;
      logic [11:0] sel;     // 1 = take pattern bit
      logic [11:0] pattern;
   } remap_cfg_t;

   // APB request side, no wait states
   typedef struct packed {
      logic                  psel;
      logic                  penable;
      logic                  pwrite;
      logic [`ERX_APB_AW-1:0] paddr;
      logic [`ERX_DW-1:0]    pwdata;
   } apb_req_t;

endpackage

// File: erx_protocol.sv
`timescale 1ns/1ps
`include "erx_cfg.svh"

module erx_protocol
(
   input  logic                   rx_lclk_div4,
   input  logic                   rst,
   input  logic                   rx_enable,
   input  logic                   rx_frame,
   input  logic [`ERX_LINK_W-1:0] rx_data,
   output logic                   pkt_access,
   output erx_pkg::emesh_packet_t pkt,
   output erx_pkg::pkt_kind_t     pkt_kind
);

   logic               beat1;     // Next framed beat is beat 1
   logic               take;      // Beat accepted this cycle
   logic [6:0]         hold_ctrl; // Beat 0 control byte
   logic [`ERX_AW-1:0] hold_dst;  // Beat 0 destination address
   erx_pkg::pkt_kind_t kind_next;

   assign take = rx_enable & rx_frame; // Disabled link ignores frames

   // Classify from the held beat 0 fields
   always_comb
   begin
      if (!hold_ctrl[0])
         kind_next = erx_pkg::PKT_READ; // Read request
      else if (hold_dst[`ERX_AW-1:`ERX_AW-12] == `ERX_ID)
         kind_next = erx_pkg::PKT_RESP; // Write to our ID is a read response
      else
         kind_next = erx_pkg::PKT_WRITE;
   end

   // Beat pairing and output strobe
   always_ff @(posedge rx_lclk_div4)
   begin
      if (rst)
      begin
         beat1      <= 1'b0;
         pkt_access <= 1'b0;
      end
      else
      begin
         pkt_access <= take & beat1; // One cycle per transaction
         if (take)
            beat1 <= ~beat1;         // Keep pairing while framed
         else
            beat1 <= 1'b0;           // Frame low restarts at beat 0
      end
   end

   // Beat 0 hold and packet assembly
   always_ff @(posedge rx_lclk_div4)
   begin
      if (take & ~beat1)
      begin
         hold_ctrl <= rx_data[6:0];  // Bit 7 unused
         hold_dst  <= rx_data[39:8]; // Bytes 1..4
      end
      if (take & beat1)
      begin
         pkt.write    <= hold_ctrl[0];
         pkt.datamode <= hold_ctrl[2:1];
         pkt.ctrlmode <= hold_ctrl[6:3];
         pkt.dstaddr  <= hold_dst;
         pkt.data     <= rx_data[31:0];  // Low word
         pkt.srcaddr  <= rx_data[63:32]; // High word
         pkt_kind     <= kind_next;
      end
   end

endmodule

// File: erx_remap.sv
`timescale 1ns/1ps
`include "erx_cfg.svh"

module erx_remap
(
   input  logic                   rx_lclk_div4,
   input  logic                   rst,
   input  erx_pkg::remap_cfg_t    remap,
   input  logic                   in_access,
   input  erx_pkg::emesh_packet_t in_pkt,
   input  erx_pkg::pkt_kind_t     in_kind,
   output logic                   out_access,
   output erx_pkg::emesh_packet_t out_pkt,
   output erx_pkg::pkt_kind_t     out_kind
);

   logic                   remap_on;
   logic [11:0]            dst_hi;   // Remapped top address bits
   erx_pkg::emesh_packet_t pkt_next;

   // Responses carry our own ID and pass untouched
   assign remap_on = (remap.mode == erx_pkg::REMAP_STATIC) &&
                     (in_kind != erx_pkg::PKT_RESP);

   assign dst_hi = (remap.pattern & remap.sel) |
                   (in_pkt.dstaddr[`ERX_AW-1:`ERX_AW-12] & ~remap.sel);

   always_comb
   begin
      pkt_next = in_pkt;
      if (remap_on)
         pkt_next.dstaddr[`ERX_AW-1:`ERX_AW-12] = dst_hi;
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (rst)
         out_access <= 1'b0;
      else
         out_access <= in_access;
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      out_pkt  <= pkt_next;
      out_kind <= in_kind; // Kind follows packet
   end

endmodule

// File: erx_disty.sv
`timescale 1ns/1ps
`include "erx_cfg.svh"

module erx_disty
(
   input  logic                   rx_lclk_div4,
   input  logic                   rst,
   input  logic                   in_access,
   input  erx_pkg::emesh_packet_t in_pkt,
   input  erx_pkg::pkt_kind_t     in_kind,
   input  logic                   wr_full,
   input  logic                   rd_full,
   input  logic                   rr_full,
   output logic                   wr_push,
   output logic                   rd_push,
   output logic                   rr_push,
   output erx_pkg::emesh_packet_t push_pkt,
   output logic                   rx_wr_wait,
   output logic                   rx_rd_wait
);

   // One push strobe per accepted packet
   always_ff @(posedge rx_lclk_div4)
   begin
      if (rst)
      begin
         wr_push <= 1'b0;
         rd_push <= 1'b0;
         rr_push <= 1'b0;
      end
      else
      begin
         wr_push <= in_access & (in_kind == erx_pkg::PKT_WRITE);
         rd_push <= in_access & (in_kind == erx_pkg::PKT_READ);
         rr_push <= in_access & (in_kind == erx_pkg::PKT_RESP);
      end
   end

   // Shared payload for all three queues
   always_ff @(posedge rx_lclk_div4)
   begin
      if (in_access)
         push_pkt <= in_pkt;
   end

   // Writes and responses share the write pushback wire
   assign rx_wr_wait = wr_full | rr_full;
   assign rx_rd_wait = rd_full;

endmodule

// File: erx_fifo.sv
`timescale 1ns/1ps
`include "erx_cfg.svh"

module erx_fifo
#(
   parameter int DEPTH = `ERX_FIFO_DEPTH // Power of two
)
(
   input  logic                   rx_lclk_div4,
   input  logic                   rst,
   input  logic                   push,
   input  erx_pkg::emesh_packet_t push_pkt,
   input  logic                   wait_in,
   output logic                   access,
   output erx_pkg::emesh_packet_t packet,
   output logic                   prog_full
);

   localparam int AW = $clog2(DEPTH);
   localparam logic [AW:0] FULL_LVL = (AW+1)'(DEPTH);
   localparam logic [AW:0] PF_LVL   = (AW+1)'(DEPTH - `ERX_FIFO_MARGIN);

   erx_pkg::emesh_packet_t mem [DEPTH];
   logic [AW-1:0]          wr_ptr;
   logic [AW-1:0]          rd_ptr;
   logic [AW:0]            count;    // Entries held
   logic                   full;
   logic                   do_push;
   logic                   do_pop;

   assign full      = (count == FULL_LVL);
   assign access    = (count != '0);       // Head valid while non-empty
   assign packet    = mem[rd_ptr];         // Show-ahead head
   assign prog_full = (count >= PF_LVL);
   assign do_push   = push & ~full;        // Overflow is dropped
   assign do_pop    = access & ~wait_in;

   always_ff @(posedge rx_lclk_div4)
   begin
      if (do_push)
         mem[wr_ptr] <= push_pkt;
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + AW'(1); // Wraps at DEPTH
         if (do_pop)
            rd_ptr <= rd_ptr + AW'(1);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // Both or neither
         endcase
      end
   end

endmodule

// File: erx_regs.sv
`timescale 1ns/1ps
`include "erx_cfg.svh"

module erx_regs
(
   input  logic                rx_lclk_div4,
   input  logic                rst,
   input  erx_pkg::apb_req_t   apb,
   output logic [`ERX_DW-1:0]  prdata,
   output logic                rx_enable,
   output erx_pkg::remap_cfg_t remap
);

   logic [1:0]  cfg_reg; // bit0 enable, bit1 remap mode
   logic [11:0] sel_reg;
   logic [11:0] pat_reg;
   logic        apb_wr;

   // Access phase write, no wait states
   assign apb_wr = apb.psel & apb.penable & apb.pwrite;

   always_ff @(posedge rx_lclk_div4)
   begin
      if (rst)
      begin
         cfg_reg <= '0;
         sel_reg <= '0;
         pat_reg <= '0;
      end
      else if (apb_wr)
      begin
         case (apb.paddr)
            `ERX_REG_CFG: cfg_reg <= apb.pwdata[1:0];
            `ERX_REG_SEL: sel_reg <= apb.pwdata[11:0];
            `ERX_REG_PAT: pat_reg <= apb.pwdata[11:0];
            default:      ; // Unmapped writes ignored
         endcase
      end
   end

   // Readback straight from paddr
   always_comb
   begin
      prdata = '0;
      if (apb.psel)
      begin
         case (apb.paddr)
            `ERX_REG_CFG: prdata = {{(`ERX_DW-2){1'b0}}, cfg_reg};
            `ERX_REG_SEL: prdata = {{(`ERX_DW-12){1'b0}}, sel_reg};
            `ERX_REG_PAT: prdata = {{(`ERX_DW-12){1'b0}}, pat_reg};
            default:      prdata = '0;
         endcase
      end
   end

   assign rx_enable     = cfg_reg[0];
   assign remap.mode    = erx_pkg::remap_mode_t'(cfg_reg[1]);
   assign remap.sel     = sel_reg;
   assign remap.pattern = pat_reg;

endmodule

// File: erx_top.sv
`timescale 1ns/1ps
`include "erx_cfg.svh"

module erx_top
(
   input  logic                   rx_lclk_div4,
   input  logic                   rst,
   input  logic                   rx_frame,
   input  logic [`ERX_LINK_W-1:0] rx_data,
   output logic                   rx_wr_wait,
   output logic                   rx_rd_wait,
   input  erx_pkg::apb_req_t      apb,
   output logic [`ERX_DW-1:0]     prdata,
   output logic                   rxwr_access,
   output erx_pkg::emesh_packet_t rxwr_packet,
   input  logic                   rxwr_wait,
   output logic                   rxrd_access,
   output erx_pkg::emesh_packet_t rxrd_packet,
   input  logic                   rxrd_wait,
   output logic                   rxrr_access,
   output erx_pkg::emesh_packet_t rxrr_packet,
   input  logic                   rxrr_wait
);

   logic                   rx_enable;
   erx_pkg::remap_cfg_t    remap_cfg;
   logic                   proto_access; // Decoder stage
   erx_pkg::emesh_packet_t proto_pkt;
   erx_pkg::pkt_kind_t     proto_kind;
   logic                   remap_access; // Remap stage
   erx_pkg::emesh_packet_t remap_pkt;
   erx_pkg::pkt_kind_t     remap_kind;
   logic                   wr_push;      // Distributor strobes
   logic                   rd_push;
   logic                   rr_push;
   erx_pkg::emesh_packet_t push_pkt;
   logic                   wr_full;      // Programmable-full flags
   logic                   rd_full;
   logic                   rr_full;

   erx_regs u_regs
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .apb          (apb),
      .prdata       (prdata),
      .rx_enable    (rx_enable),
      .remap        (remap_cfg)
   );

   erx_protocol u_protocol
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .rx_enable    (rx_enable),
      .rx_frame     (rx_frame),
      .rx_data      (rx_data),
      .pkt_access   (proto_access),
      .pkt          (proto_pkt),
      .pkt_kind     (proto_kind)
   );

   erx_remap u_remap
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .remap        (remap_cfg),
      .in_access    (proto_access),
      .in_pkt       (proto_pkt),
      .in_kind      (proto_kind),
      .out_access   (remap_access),
      .out_pkt      (remap_pkt),
      .out_kind     (remap_kind)
   );

   erx_disty u_disty
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .in_access    (remap_access),
      .in_pkt       (remap_pkt),
      .in_kind      (remap_kind),
      .wr_full      (wr_full),
      .rd_full      (rd_full),
      .rr_full      (rr_full),
      .wr_push      (wr_push),
      .rd_push      (rd_push),
      .rr_push      (rr_push),
      .push_pkt     (push_pkt),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait)
   );

   // Write queue
   erx_fifo #(.DEPTH(`ERX_FIFO_DEPTH)) u_wr_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .push         (wr_push),
      .push_pkt     (push_pkt),
      .wait_in      (rxwr_wait),
      .access       (rxwr_access),
      .packet       (rxwr_packet),
      .prog_full    (wr_full)
   );

   // Read request queue
   erx_fifo #(.DEPTH(`ERX_FIFO_DEPTH)) u_rd_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .push         (rd_push),
      .push_pkt     (push_pkt),
      .wait_in      (rxrd_wait),
      .access       (rxrd_access),
      .packet       (rxrd_packet),
      .prog_full    (rd_full)
   );

   // Read response queue
   erx_fifo #(.DEPTH(`ERX_FIFO_DEPTH)) u_rr_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .push         (rr_push),
      .push_pkt     (push_pkt),
      .wait_in      (rxrr_wait),
      .access       (rxrr_access),
      .packet       (rxrr_packet),
      .prog_full    (rr_full)
   );

endmodule

// File: tb_erx_assert.sv
`timescale 1ns/1ps

module erx_fifo_assert
(
   input logic                   clk,
   input logic                   rst,
   input logic                   push,
   input logic                   full,
   input logic                   access,
   input logic                   wait_in,
   input erx_pkg::emesh_packet_t packet
);

   // Stalled head holds still
   a_hold: assert property (@(posedge clk) disable iff (rst)
      access && wait_in |=> access && $stable(packet))
      else $error("Queue head moved while wait was high");

   a_reset: assert property (@(posedge clk) rst |=> !access)
      else $error("Queue access high right after reset");

   // Stimulus obeys pushback, so never full on push
   a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full)
      else $error("Push arrived while the queue was full");

endmodule

bind erx_fifo erx_fifo_assert u_fifo_assert
(
   .clk     (rx_lclk_div4),
   .rst     (rst),
   .push    (push),
   .full    (full),
   .access  (access),
   .wait_in (wait_in),
   .packet  (packet)
);

// File: tb_erx.sv
`timescale 1ns/1ps
`include "erx_cfg.svh"

module tb_erx;

   // One transaction of the stimulus table
   typedef struct packed {
      logic [2:0]         test;     // Behavior number
      logic               enable;   // rx_enable while sent
      logic               remap;    // Static remap on
      logic [11:0]        sel;
      logic [11:0]        pattern;
      logic               write;
      logic [1:0]         datamode;
      logic [3:0]         ctrlmode;
      logic [`ERX_AW-1:0] dstaddr;
      erx_pkg::pkt_kind_t exp_kind; // Expected queue
   } txn_row_t;

   localparam logic [31:0] SEED = 32'h143b60ef;
   localparam logic [31:0] TAPS = 32'h80200003; // x^32+x^22+x^2+x+1

   logic                   rx_lclk_div4;
   logic                   rst;
   logic                   rx_frame;
   logic [`ERX_LINK_W-1:0] rx_data;
   logic                   rx_wr_wait;
   logic                   rx_rd_wait;
   erx_pkg::apb_req_t      apb;
   logic [`ERX_DW-1:0]     prdata;
   logic                   rxwr_access;
   erx_pkg::emesh_packet_t rxwr_packet;
   logic                   rxwr_wait = 1'b0;
   logic                   rxrd_access;
   erx_pkg::emesh_packet_t rxrd_packet;
   logic                   rxrd_wait = 1'b0;
   logic                   rxrr_access;
   erx_pkg::emesh_packet_t rxrr_packet;
   logic                   rxrr_wait = 1'b0;

   txn_row_t               rows[$];      // Stimulus table
   erx_pkg::emesh_packet_t sb_wr[$];     // Per-queue scoreboards
   erx_pkg::emesh_packet_t sb_rd[$];
   erx_pkg::emesh_packet_t sb_rr[$];
   logic [31:0]            data_lfsr;
   logic [31:0]            wait_lfsr;
   logic                   rand_wait;    // Random consumer stalls
   logic                   hold_wr;      // Write consumer held off
   logic                   table_ready = 1'b0;
   logic [25:0]            cur_cfg;      // {enable, remap, sel, pattern}
   int                     errors;
   int                     checks;
   int                     test_err_start;
   int                     tests_run;
   int                     tests_bad;

   erx_top UUT
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst          (rst),
      .rx_frame     (rx_frame),
      .rx_data      (rx_data),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait),
      .apb          (apb),
      .prdata       (prdata),
      .rxwr_access  (rxwr_access),
      .rxwr_packet  (rxwr_packet),
      .rxwr_wait    (rxwr_wait),
      .rxrd_access  (rxrd_access),
      .rxrd_packet  (rxrd_packet),
      .rxrd_wait    (rxrd_wait),
      .rxrr_access  (rxrr_access),
      .rxrr_packet  (rxrr_packet),
      .rxrr_wait    (rxrr_wait)
   );

   always #4 rx_lclk_div4 = ~rx_lclk_div4; // 8 ns period

   // Galois step, returns the bit shifted out
   function automatic logic step_lfsr(inout logic [31:0] st);
      logic b;
      b  = st[0];
      st = st >> 1;
      if (b)
         st = st ^ TAPS;
      return b;
   endfunction

   function automatic logic [63:0] rand_bits(int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v[i] = step_lfsr(data_lfsr); // One step per bit
      return v;
   endfunction

   // Packet as the consumer should see it
   function automatic erx_pkg::emesh_packet_t expected_packet(txn_row_t r, logic [31:0] data,
                                                             logic [31:0] src);
      erx_pkg::emesh_packet_t p;
      p.write    = r.write;
      p.datamode = r.datamode;
      p.ctrlmode = r.ctrlmode;
      p.dstaddr  = r.dstaddr;
      p.data     = data;
      p.srcaddr  = src;
      if (r.remap && r.exp_kind != erx_pkg::PKT_RESP)
         for (int b = 0; b < 12; b++)
            if (r.sel[b])
               p.dstaddr[20 + b] = r.pattern[b]; // Selected bits take pattern
      return p;
   endfunction

   function automatic string test_name(int t);
      case (t)
         1:       return "register reset and readback";
         2:       return "writes in order under random wait";
         3:       return "read requests and responses";
         4:       return "static remap";
         5:       return "write pushback and drain";
         default: return "frames ignored while disabled";
      endcase
   endfunction

   task automatic check_packet(string what, erx_pkg::emesh_packet_t got,
                               erx_pkg::emesh_packet_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error @ %0t: %s packet %h, expected %h", $realtime, what, got, exp);
      end
   endtask

   task automatic check_reg(string what, logic [31:0] got, logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error @ %0t: %s read %h, expected %h", $realtime, what, got, exp);
      end
   endtask

   task automatic check_flag(string what, logic got, logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error @ %0t: %s is %b, expected %b", $realtime, what, got, exp);
      end
   endtask

   task automatic add_row(logic [2:0] test, logic en, logic rm, logic [11:0] sel,
                          logic [11:0] pat, logic wr, logic [1:0] dm, logic [3:0] cm,
                          logic [31:0] dst, erx_pkg::pkt_kind_t kind);
      txn_row_t r;
      r.test     = test;
      r.enable   = en;
      r.remap    = rm;
      r.sel      = sel;
      r.pattern  = pat;
      r.write    = wr;
      r.datamode = dm;
      r.ctrlmode = cm;
      r.dstaddr  = dst;
      r.exp_kind = kind;
      rows.push_back(r);
   endtask

   task automatic build_table;
      for (int i = 0; i < 8; i++)
         add_row(2, 1, 0, 0, 0, 1, 2'(i), 4'(i), 32'h1000_0000 + i * 32'h0010_0004,
                 erx_pkg::PKT_WRITE);
      add_row(3, 1, 0, 0, 0, 0, 2, 4'h0, 32'h2000_0040, erx_pkg::PKT_READ);
      add_row(3, 1, 0, 0, 0, 1, 2, 4'h0, 32'h8000_0100, erx_pkg::PKT_RESP);
      add_row(3, 1, 0, 0, 0, 0, 1, 4'h3, 32'h8001_0200, erx_pkg::PKT_READ); // Read to own ID
      add_row(3, 1, 0, 0, 0, 1, 3, 4'h1, 32'h800F_FFFC, erx_pkg::PKT_RESP);
      add_row(3, 1, 0, 0, 0, 1, 0, 4'h0, 32'h8010_0000, erx_pkg::PKT_WRITE); // 0x801 not ours
      add_row(3, 1, 0, 0, 0, 0, 3, 4'hF, 32'hFFF0_0008, erx_pkg::PKT_READ);
      add_row(4, 1, 1, 12'hF00, 12'h3A5, 1, 2, 4'h0, 32'h1230_0000, erx_pkg::PKT_WRITE);
      add_row(4, 1, 1, 12'hF00, 12'h3A5, 0, 2, 4'h0, 32'hA550_0010, erx_pkg::PKT_READ);
      add_row(4, 1, 1, 12'hF00, 12'h3A5, 1, 2, 4'h0, 32'h8000_0020, erx_pkg::PKT_RESP);
      add_row(4, 1, 1, 12'h0F0, 12'hC3C, 1, 1, 4'h2, 32'h4560_0030, erx_pkg::PKT_WRITE);
      add_row(4, 1, 1, 12'h0F0, 12'hC3C, 0, 1, 4'h2, 32'h7890_0040, erx_pkg::PKT_READ);
      add_row(4, 1, 1, 12'h5A5, 12'hFFF, 1, 0, 4'h4, 32'h0000_0050, erx_pkg::PKT_WRITE);
      add_row(4, 1, 1, 12'hFFF, 12'h800, 1, 0, 4'h0, 32'h1230_0060, erx_pkg::PKT_WRITE);
      for (int i = 0; i < 12; i++)
         add_row(5, 1, 0, 0, 0, 1, 2, 4'h0, 32'h0200_0000 + i * 4, erx_pkg::PKT_WRITE);
      add_row(6, 0, 0, 0, 0, 1, 2, 4'h0, 32'h0300_0000, erx_pkg::PKT_WRITE);
      add_row(6, 0, 0, 0, 0, 0, 2, 4'h0, 32'h0300_0004, erx_pkg::PKT_READ);
      add_row(6, 0, 0, 0, 0, 1, 2, 4'h0, 32'h8000_0008, erx_pkg::PKT_RESP);
   endtask

   // All tasks below start and end 1 ns after a rising edge
   task automatic apb_write(logic [7:0] addr, logic [31:0] data);
      apb.psel    = 1'b1;
      apb.pwrite  = 1'b1;
      apb.paddr   = addr;
      apb.pwdata  = data;
      apb.penable = 1'b0;               // Setup phase
      @(posedge rx_lclk_div4) #1;
      apb.penable = 1'b1;               // Access phase, write lands here
      @(posedge rx_lclk_div4) #1;
      apb = '0;
   endtask

   task automatic apb_read(logic [7:0] addr, output logic [31:0] data);
      apb.psel    = 1'b1;
      apb.pwrite  = 1'b0;
      apb.paddr   = addr;
      apb.penable = 1'b0;
      @(negedge rx_lclk_div4);
      data = prdata;                    // Combinational during psel
      @(posedge rx_lclk_div4) #1;
      apb.penable = 1'b1;
      @(posedge rx_lclk_div4) #1;
      apb = '0;
   endtask

   task automatic read_expect(logic [7:0] addr, logic [31:0] exp);
      logic [31:0] rd;
      apb_read(addr, rd);
      check_reg($sformatf("register 0x%02h", addr), rd, exp);
   endtask

   // Write, then read back only the implemented bits
   task automatic write_readback(logic [7:0] addr, logic [31:0] wdata, logic [31:0] mask);
      apb_write(addr, wdata);
      read_expect(addr, wdata & mask);
   endtask

   task automatic reg_test;
      @(negedge rx_lclk_div4);
      check_flag("rxwr_access after reset", rxwr_access, 1'b0);
      check_flag("rxrd_access after reset", rxrd_access, 1'b0);
      check_flag("rxrr_access after reset", rxrr_access, 1'b0);
      check_flag("rx_wr_wait after reset", rx_wr_wait, 1'b0);
      check_flag("rx_rd_wait after reset", rx_rd_wait, 1'b0);
      @(posedge rx_lclk_div4) #1;
      read_expect(`ERX_REG_CFG, 32'h0);
      read_expect(`ERX_REG_SEL, 32'h0);
      read_expect(`ERX_REG_PAT, 32'h0);
      write_readback(`ERX_REG_CFG, 32'hFFFF_FFFE, 32'h0000_0003); // Remap bit, no enable
      write_readback(`ERX_REG_SEL, 32'h1234_5A5C, 32'h0000_0FFF);
      write_readback(`ERX_REG_PAT, 32'hFFFF_F3C3, 32'h0000_0FFF);
      write_readback(8'h0C, 32'hFFFF_FFFF, 32'h0);                // Unmapped
      write_readback(8'h10, 32'hFFFF_FFFF, 32'h0);
      write_readback(`ERX_REG_CFG, 32'h0, 32'h3);
      write_readback(`ERX_REG_SEL, 32'h0, 32'hFFF);
      write_readback(`ERX_REG_PAT, 32'h0, 32'hFFF);
   endtask

   task automatic apply_cfg(txn_row_t r);
      write_readback(`ERX_REG_CFG, {30'h0, r.remap, r.enable}, 32'h3);
      write_readback(`ERX_REG_SEL, {20'h0, r.sel}, 32'hFFF);
      write_readback(`ERX_REG_PAT, {20'h0, r.pattern}, 32'hFFF);
   endtask

   // Two framed beats, frame left high for back-to-back pairing
   task automatic send_txn(txn_row_t r);
      logic [63:0] bits;
      logic [31:0] data;
      logic [31:0] src;
      logic [24:0] pad;
      bits     = rand_bits(32);
      data     = bits[31:0];
      bits     = rand_bits(32);
      src      = bits[31:0];
      bits     = rand_bits(25);
      pad      = bits[24:0];            // Junk in unused bits
      rx_frame = 1'b1;
      rx_data  = {pad[24:1], r.dstaddr, pad[0], r.ctrlmode, r.datamode, r.write};
      @(posedge rx_lclk_div4) #1;
      rx_data  = {src, data};           // Beat 1
      @(posedge rx_lclk_div4) #1;
      if (r.enable)
      begin
         case (r.exp_kind)
            erx_pkg::PKT_WRITE: sb_wr.push_back(expected_packet(r, data, src));
            erx_pkg::PKT_READ:  sb_rd.push_back(expected_packet(r, data, src));
            default:            sb_rr.push_back(expected_packet(r, data, src));
         endcase
      end
   endtask

   task automatic link_idle;
      rx_frame = 1'b0;
      rx_data  = '0;
      @(posedge rx_lclk_div4) #1;
   endtask

   task automatic drain_queues;
      repeat (5) @(posedge rx_lclk_div4); // Let the pipeline empty
      while (sb_wr.size() + sb_rd.size() + sb_rr.size() != 0)
         @(posedge rx_lclk_div4);
      #1;
   endtask

   // Called right after the 10th held write's beat 1 edge k
   task automatic check_pushback_rise;
      link_idle();                                // Edge k+1
      @(posedge rx_lclk_div4);                    // Edge k+2, 9 stored
      @(negedge rx_lclk_div4);
      check_flag("rx_wr_wait with 9 writes held", rx_wr_wait, 1'b0);
      @(posedge rx_lclk_div4);                    // Edge k+3, 10th stored
      @(negedge rx_lclk_div4);
      check_flag("rx_wr_wait with 10 writes held", rx_wr_wait, 1'b1);
      @(posedge rx_lclk_div4) #1;
   endtask

   task automatic start_test(int t);
      test_err_start = errors;
      rand_wait      = (t >= 2 && t <= 4);
      hold_wr        = (t == 5);
   endtask

   task automatic report_test(int t);
      tests_run++;
      if (errors == test_err_start)
         $display("T%0d %s: ok", t, test_name(t));
      else
      begin
         tests_bad++;
         $display("T%0d %s: %0d errors", t, test_name(t), errors - test_err_start);
      end
   endtask

   task automatic finish_test(int t);
      link_idle();
      if (t == 5)
      begin
         repeat (3) @(posedge rx_lclk_div4);
         @(negedge rx_lclk_div4);
         check_flag("rx_wr_wait with 12 writes held", rx_wr_wait, 1'b1);
         check_flag("rxwr_access while held", rxwr_access, 1'b1);
         @(posedge rx_lclk_div4) #1;
         hold_wr = 1'b0;                          // Release the consumer
      end
      if (t == 6)
      begin
         repeat (8)
         begin
            @(negedge rx_lclk_div4);
            check_flag("rxwr_access while disabled", rxwr_access, 1'b0);
            check_flag("rxrd_access while disabled", rxrd_access, 1'b0);
            check_flag("rxrr_access while disabled", rxrr_access, 1'b0);
         end
         @(posedge rx_lclk_div4) #1;
      end
      drain_queues();
      if (t == 5)
      begin
         @(negedge rx_lclk_div4);
         check_flag("rx_wr_wait after drain", rx_wr_wait, 1'b0);
         @(posedge rx_lclk_div4) #1;
      end
      rand_wait = 1'b0;
      report_test(t);
   endtask

   // Consumer wait drivers
   always @(posedge rx_lclk_div4)
   begin
      #1;
      if (hold_wr)
         rxwr_wait = 1'b1;
      else
         rxwr_wait = rand_wait ? step_lfsr(wait_lfsr) : 1'b0;
      rxrd_wait = rand_wait ? step_lfsr(wait_lfsr) : 1'b0;
      rxrr_wait = rand_wait ? step_lfsr(wait_lfsr) : 1'b0;
   end

   // Consumers, an entry leaves when access is high and wait low
   always @(negedge rx_lclk_div4)
   begin
      if (!rst && rxwr_access && !rxwr_wait)
      begin
         if (sb_wr.size() == 0)
         begin
            errors++;
            $display("Unexpected packet on the write queue at %0t", $realtime);
         end
         else
            check_packet("write queue", rxwr_packet, sb_wr.pop_front());
      end
      if (!rst && rxrd_access && !rxrd_wait)
      begin
         if (sb_rd.size() == 0)
         begin
            errors++;
            $display("Unexpected packet on the read queue at %0t", $realtime);
         end
         else
            check_packet("read queue", rxrd_packet, sb_rd.pop_front());
      end
      if (!rst && rxrr_access && !rxrr_wait)
      begin
         if (sb_rr.size() == 0)
         begin
            errors++;
            $display("Unexpected packet on the response queue at %0t", $realtime);
         end
         else
            check_packet("response queue", rxrr_packet, sb_rr.pop_front());
      end
   end

   // Watchdog, 200 cycles per row plus 1000
   initial
   begin
      wait (table_ready);
      repeat (200 * rows.size() + 1000) @(posedge rx_lclk_div4);
      $display("Timeout: the run did not finish within %0d cycles", 200 * rows.size() + 1000);
      $display("Test failed");
      $finish;
   end

   initial
   begin
      txn_row_t r;
      int       cur_test;
      int       held_writes;
      $timeformat(-9, 0, " ns", 0);
      rx_lclk_div4 = 1'b0;
      rst          = 1'b1;
      rx_frame     = 1'b0;
      rx_data      = '0;
      apb          = '0;
      data_lfsr    = SEED;
      wait_lfsr    = SEED;
      rand_wait    = 1'b0;
      hold_wr      = 1'b0;
      cur_cfg      = '0;    // Register reset values
      errors       = 0;
      checks       = 0;
      tests_run    = 0;
      tests_bad    = 0;
      cur_test     = 0;
      held_writes  = 0;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge rx_lclk_div4);
      #1;
      rst = 1'b0;
      start_test(1);
      reg_test();
      report_test(1);
      for (int i = 0; i < rows.size(); i++)
      begin
         r = rows[i];
         if (int'(r.test) != cur_test)
         begin
            if (cur_test != 0)
               finish_test(cur_test);
            start_test(int'(r.test));
            cur_test = int'(r.test);
         end
         if ({r.enable, r.remap, r.sel, r.pattern} != cur_cfg)
         begin
            link_idle();
            drain_queues();  // No traffic across a config change
            apply_cfg(r);
            cur_cfg = {r.enable, r.remap, r.sel, r.pattern};
         end
         send_txn(r);
         if (r.test == 3'd5)
         begin
            held_writes++;
            if (held_writes == 10)
               check_pushback_rise();
         end
      end
      finish_test(cur_test);
      $display("Tests run %0d, tests with errors %0d, checks %0d, errors %0d",
               tests_run, tests_bad, checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: erx.f
+incdir+.
erx_pkg.sv
erx_protocol.sv
erx_remap.sv
erx_disty.sv
erx_fifo.sv
erx_regs.sv
erx_top.sv
tb_erx_assert.sv
tb_erx.sv

// File: Makefile
# Verilator build and run for the receive path testbench

VERILATOR ?= verilator
TOP       ?= tb_erx
FILELIST  ?= erx.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test passed

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) erx_cfg.svh

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
